//--- logic/credit_apb_regs.sv
// APB slave with no wait states; only reg_withhold is writable and a write to reg_flits clears it.
`timescale 1ns/100ps
`default_nettype none

module credit_apb_regs (
  input  logic                      clk,
  input  logic                      arst_n,
  // APB port.
  input  credit_regs_pkg::apb_req_t apb_req,
  output credit_regs_pkg::apb_rsp_t apb_rsp,
  // Credit control out to the sender.
  output credit_link_pkg::credit_t  withhold,
  // Status in from the sender.
  input  credit_link_pkg::credit_t  credit_count,
  input  credit_link_pkg::credit_t  credit_available,
  input  logic                      sent
);

  localparam int cw = credit_link_pkg::credit_width;

  logic                         access;
  logic                         wr_access;
  credit_link_pkg::credit_t     withhold_q;
  credit_regs_pkg::flit_count_t flits_q;

  // ------------------------------
  // Access decode
  // ------------------------------

  // Only the access phase does anything. The setup phase just presents the address.
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;

  // Withhold register, which starts at zero so the full pool is usable.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      withhold_q <= '0;
    end else if (wr_access && (apb_req.paddr == credit_regs_pkg::reg_withhold)) begin
      withhold_q <= apb_req.pwdata[cw-1:0];
    end
  end

  assign withhold = withhold_q;

  // Sent-flit counter. A clear in the same cycle as a sent pulse wins,
  // so that flit is not counted.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flits_q <= '0;
    end else if (wr_access && (apb_req.paddr == credit_regs_pkg::reg_flits)) begin
      flits_q <= '0;
    end else if (sent) begin
      flits_q <= flits_q + 1'b1;
    end
  end

  // ------------------------------
  // Read data and errors
  // ------------------------------

  // Read data follows the address, so it is valid throughout the access phase.
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.prdata  = '0;
    apb_rsp.pslverr = 1'b0;
    case (apb_req.paddr)
      credit_regs_pkg::reg_withhold: begin
        apb_rsp.prdata = credit_regs_pkg::apb_data_t'(withhold_q);
      end
      credit_regs_pkg::reg_count: begin
        apb_rsp.prdata  = credit_regs_pkg::apb_data_t'(credit_count);
        apb_rsp.pslverr = wr_access;
      end
      credit_regs_pkg::reg_available: begin
        apb_rsp.prdata  = credit_regs_pkg::apb_data_t'(credit_available);
        apb_rsp.pslverr = wr_access;
      end
      credit_regs_pkg::reg_flits: begin
        apb_rsp.prdata = flits_q;
      end
      default: begin
        // Offsets outside the map fail on both reads and writes.
        apb_rsp.pslverr = access;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/credit_counter.sv
// Credits move by single steps only, and max_credit must fit in the credit field width.
`timescale 1ns/100ps
`default_nettype none

module credit_counter #(
  // Reset value of the counter, which is the full credit pool.
  parameter int max_credit = credit_link_pkg::max_credit_default
) (
  input  logic                     clk,
  input  logic                     arst_n,
  // One credit returns in this cycle.
  input  logic                     incr,
  // Request to spend one credit, and the grant for it.
  input  logic                     decr_valid,
  output logic                     decr_ready,
  // Credits kept out of circulation.
  input  credit_link_pkg::credit_t withhold,
  // Count before this cycle's change, and the credit that can be spent now.
  output credit_link_pkg::credit_t value,
  output credit_link_pkg::credit_t available
);

  localparam int cw = credit_link_pkg::credit_width;
  localparam credit_link_pkg::credit_t reset_value = credit_link_pkg::credit_t'(max_credit);

  credit_link_pkg::credit_t value_q;
  // One bit wider than a credit, so a returning credit on a full count cannot wrap.
  logic [cw:0]              value_plus;
  logic [cw:0]              withhold_ext;
  logic                     decr_accept;

  // ------------------------------
  // Available credit
  // ------------------------------

  // A credit that returns this cycle can be spent in the same cycle.
  assign value_plus   = {1'b0, value_q} + {{cw{1'b0}}, incr};
  assign withhold_ext = {1'b0, withhold};

  // The withhold can exceed the count while credits are out on the link,
  // so the difference stops at zero instead of wrapping.
  always_comb begin
    if (value_plus > withhold_ext) begin
      available = credit_link_pkg::credit_t'(value_plus - withhold_ext);
    end else begin
      available = '0;
    end
  end

  assign decr_ready  = (available != '0);
  assign decr_accept = decr_valid && decr_ready;

  // ------------------------------
  // Count register
  // ------------------------------

  // A credit in and a credit out in the same cycle cancel, and the count holds.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value_q <= reset_value;
    end else begin
      case ({incr, decr_accept})
        2'b10:   value_q <= value_q + 1'b1;
        2'b01:   value_q <= value_q - 1'b1;
        default: value_q <= value_q;
      endcase
    end
  end

  assign value = value_q;

endmodule

`default_nettype wire

//--- logic/credit_link_pkg.sv
// Link types assume a fixed 16-bit flit and an 8-bit credit field, so pools above 255 do not fit.
`default_nettype none

package credit_link_pkg;

  // ------------------------------
  // Widths and defaults
  // ------------------------------

  // Flit width. Modules take it as the default of their width parameter.
  parameter int data_width = 16;

  // Default credit pool, which is also the receiver FIFO depth.
  parameter int max_credit_default = 4;

  // Credit fields are wide enough for any pool up to 255.
  parameter int credit_width = 8;

  // ------------------------------
  // Types
  // ------------------------------

  // One flit of payload.
  typedef logic [data_width-1:0] flit_t;

  // A credit amount, such as a count, a withhold or the available credit.
  typedef logic [credit_width-1:0] credit_t;

  // Forward direction of the link. There is no ready here; a credit stands in for it.
  typedef struct packed {
    logic  valid;
    flit_t data;
  } link_fwd_t;

  // Reverse direction of the link, one credit pulse per freed slot.
  typedef struct packed {
    logic credit;
    logic credit_stall;
  } link_rev_t;

endpackage

`default_nettype wire

//--- logic/credit_link_top.sv
// Pools above the credit field range are clamped to 255, and a pool below 1 becomes 1.
`timescale 1ns/100ps
`default_nettype none

module credit_link_top #(
  parameter int width       = credit_link_pkg::data_width,
  parameter int max_credit  = credit_link_pkg::max_credit_default,
  parameter bit reg_outputs = 1'b0
) (
  input  logic                      clk,
  input  logic                      arst_n,
  // Push side.
  output logic                      push_ready,
  input  logic                      push_valid,
  input  credit_link_pkg::flit_t    push_data,
  // Output side.
  output logic                      out_valid,
  input  logic                      out_ready,
  output credit_link_pkg::flit_t    out_data,
  // APB port.
  input  credit_regs_pkg::apb_req_t apb_req,
  output credit_regs_pkg::apb_rsp_t apb_rsp
);

  // Largest pool the credit field can count.
  localparam int credit_limit = (1 << credit_link_pkg::credit_width) - 1;
  localparam int pool = (max_credit > credit_limit) ? credit_limit :
                        (max_credit < 1) ? 1 : max_credit;

  credit_link_pkg::link_fwd_t link_fwd;
  credit_link_pkg::link_rev_t link_rev;
  credit_link_pkg::credit_t   withhold;
  credit_link_pkg::credit_t   credit_count;
  credit_link_pkg::credit_t   credit_available;
  logic                       sent;

  // Sender side, which owns the credit counter.
  credit_sender #(
    .width      (width),
    .max_credit (pool),
    .reg_outputs(reg_outputs)
  ) sender_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .push_ready      (push_ready),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .link_fwd        (link_fwd),
    .link_credit     (link_rev.credit),
    .credit_stall    (link_rev.credit_stall),
    .withhold        (withhold),
    .credit_count    (credit_count),
    .credit_available(credit_available),
    .sent            (sent)
  );

  // Receiver side. Its FIFO depth matches the pool.
  credit_receiver #(
    .width     (width),
    .max_credit(pool)
  ) receiver_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .link_fwd    (link_fwd),
    .credit_stall(link_rev.credit_stall),
    .link_credit (link_rev.credit),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data)
  );

  credit_apb_regs regs_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .withhold        (withhold),
    .credit_count    (credit_count),
    .credit_available(credit_available),
    .sent            (sent)
  );

endmodule

`default_nettype wire

//--- logic/credit_receiver.sv
// Depth equals max_credit and a flit that arrives when full is dropped, so the sender must obey credits.
`timescale 1ns/100ps
`default_nettype none

module credit_receiver #(
  parameter int width      = credit_link_pkg::data_width,
  parameter int max_credit = credit_link_pkg::max_credit_default
) (
  input  logic                       clk,
  input  logic                       arst_n,
  // Link side.
  input  credit_link_pkg::link_fwd_t link_fwd,
  input  logic                       credit_stall,
  output logic                       link_credit,
  // Ready/valid output side, taken from the FIFO head.
  output logic                       out_valid,
  input  logic                       out_ready,
  output credit_link_pkg::flit_t     out_data
);

  // A pool of one still needs a one-bit pointer.
  localparam int ptr_width   = (max_credit > 1) ? $clog2(max_credit) : 1;
  localparam int count_width = $clog2(max_credit + 1);
  localparam logic [ptr_width-1:0]   last_ptr = ptr_width'(max_credit - 1);
  localparam logic [count_width-1:0] depth    = count_width'(max_credit);

  logic [width-1:0]       mem [max_credit];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count_q;
  logic                   full;
  logic                   wr_en;
  logic                   rd_en;
  logic                   credit_q;

  // ------------------------------
  // FIFO control
  // ------------------------------

  assign full  = (count_q == depth);
  // Under the credit rule the FIFO is never full when a flit arrives.
  // If it is, the flit is dropped and the stored ones stay intact.
  assign wr_en = link_fwd.valid && !full;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      // Pointers wrap by hand, since the depth need not be a power of two.
      if (wr_en) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= link_fwd.data;
    end
  end

  // The head is visible one cycle after the flit crossed the link.
  assign out_valid = (count_q != '0);
  assign out_data  = mem[rd_ptr];

  // ------------------------------
  // Credit return
  // ------------------------------

  // Each drained flit frees one slot, and the credit goes back one cycle later.
  // Nothing is returned while the sender is still coming out of reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= rd_en && !credit_stall;
    end
  end

  assign link_credit = credit_q;

endmodule

`default_nettype wire

//--- logic/credit_regs_pkg.sv
// APB map uses byte offsets within an 8-bit window and 32-bit data; no wait states are modelled.
`default_nettype none

package credit_regs_pkg;

  // ------------------------------
  // APB bus types
  // ------------------------------

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Request from the APB master.
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Response back to the master.
  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

  // ------------------------------
  // Register map
  // ------------------------------

  parameter apb_addr_t reg_withhold  = 8'h00;  // Read/write, credits held back.
  parameter apb_addr_t reg_count     = 8'h04;  // Read-only, credit count.
  parameter apb_addr_t reg_available = 8'h08;  // Read-only, available credit.
  parameter apb_addr_t reg_flits     = 8'h0C;  // Read, and a write clears it.

  // The sent-flit counter wraps at 32 bits.
  typedef logic [31:0] flit_count_t;

endpackage

`default_nettype wire

//--- logic/credit_sender.sv
// Width must equal the package flit width; credits returned while credit_stall is high are lost.
`timescale 1ns/100ps
`default_nettype none

module credit_sender #(
  parameter int width       = credit_link_pkg::data_width,
  parameter int max_credit  = credit_link_pkg::max_credit_default,
  // When 1, the link valid and data come from a register, one cycle after the push.
  parameter bit reg_outputs = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  // Ready/valid push side.
  output logic                       push_ready,
  input  logic                       push_valid,
  input  credit_link_pkg::flit_t     push_data,
  // Credit/valid link side.
  output credit_link_pkg::link_fwd_t link_fwd,
  input  logic                       link_credit,
  output logic                       credit_stall,
  // Credit control and status.
  input  credit_link_pkg::credit_t   withhold,
  output credit_link_pkg::credit_t   credit_count,
  output credit_link_pkg::credit_t   credit_available,
  output logic                       sent
);

  logic accept;
  logic stall_q;

  // Each pushed flit spends one credit, and each credit from the link returns one.
  credit_counter #(
    .max_credit(max_credit)
  ) counter_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .incr      (link_credit),
    .decr_valid(push_valid),
    .decr_ready(push_ready),
    .withhold  (withhold),
    .value     (credit_count),
    .available (credit_available)
  );

  assign accept = push_valid && push_ready;
  assign sent   = accept;

  // The stall is high in reset and for one cycle after it, which keeps the
  // receiver from returning credits before the counter holds its full pool.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stall_q <= 1'b1;
    end else begin
      stall_q <= 1'b0;
    end
  end

  assign credit_stall = stall_q;

  // ------------------------------
  // Link forward path
  // ------------------------------

  if (reg_outputs) begin : gen_reg_out
    logic             valid_q;
    logic [width-1:0] data_q;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= accept;
      end
    end

    // Payload only loads on an accepted flit.
    always_ff @(posedge clk) begin
      if (accept) begin
        data_q <= push_data;
      end
    end

    assign link_fwd.valid = valid_q;
    assign link_fwd.data  = data_q;
  end else begin : gen_pass_out
    assign link_fwd.valid = accept;
    assign link_fwd.data  = push_data;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the credit link testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module credit_link_tb \
  -f verilog.f -o credit_link_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/credit_link_sim > sim.log 2>&1 \
  || { echo "Simulation exited abnormally, see sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

//--- tests/credit_link_tb.sv
// Testbench for a 16-bit link with a pool of 4 and no output register; tests run in a fixed order.
`timescale 1ns/100ps
`default_nettype none

module credit_link_tb;

  localparam int max_credit     = 4;
  localparam int drive_delay    = 5;
  // The directed tests take about 400 cycles, so allow five times that.
  localparam int test_cycles    = 400;
  localparam int timeout_cycles = 5 * test_cycles;

  logic                      clk;
  logic                      arst_n;
  logic                      push_ready;
  logic                      push_valid;
  credit_link_pkg::flit_t    push_data;
  logic                      out_valid;
  logic                      out_ready;
  credit_link_pkg::flit_t    out_data;
  credit_regs_pkg::apb_req_t apb_req;
  credit_regs_pkg::apb_rsp_t apb_rsp;

  integer                    seed;
  int                        error_count;
  int                        check_count;
  int                        cycle_count;
  int                        total_flits;
  // Flits in push order, and flits as they left the output side.
  credit_link_pkg::flit_t    expected_q[$];
  credit_link_pkg::flit_t    got_q[$];

  credit_link_top #(
    .width     (16),
    .max_credit(max_credit)
  ) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_ready(push_ready),
    .push_valid(push_valid),
    .push_data (push_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  // 100 ns clock period.
  always #50 clk = ~clk;

  // The run ends here if the tests stall somewhere.
  initial begin : timeout_watch
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Simulation timed out after %0d cycles", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------
  // Checker and bus tasks
  // ------------------------------

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    check_count++;
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  // Inputs change at the drive point and outputs are sampled on the falling edge.
  task automatic apb_transfer(input credit_regs_pkg::apb_addr_t addr, input logic write,
                              input credit_regs_pkg::apb_data_t wdata,
                              output credit_regs_pkg::apb_data_t rdata, output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #drive_delay;
    apb_req.penable = 1'b1;
    @(negedge clk);
    // The slave has no wait states, so pready is due in the first access cycle.
    check(32'(apb_rsp.pready), 1, "pready in the access phase");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    #drive_delay;
    apb_req = '0;
  endtask

  task automatic apb_write(input credit_regs_pkg::apb_addr_t addr,
                           input credit_regs_pkg::apb_data_t data, output logic slverr);
    credit_regs_pkg::apb_data_t unused;
    apb_transfer(addr, 1'b1, data, unused, slverr);
  endtask

  task automatic apb_read(input credit_regs_pkg::apb_addr_t addr,
                          output credit_regs_pkg::apb_data_t data, output logic slverr);
    apb_transfer(addr, 1'b0, '0, data, slverr);
  endtask

  // Polls the credit count until it settles, then checks it.
  task automatic wait_count(input logic [31:0] expected, input string what);
    credit_regs_pkg::apb_data_t value;
    logic                       err;
    int                         polls;
    polls = 0;
    apb_read(credit_regs_pkg::reg_count, value, err);
    while ((value != expected) && (polls < 10)) begin
      apb_read(credit_regs_pkg::reg_count, value, err);
      polls++;
    end
    check(value, expected, what);
  endtask

  // ------------------------------
  // Flit tasks
  // ------------------------------

  // Each flit holds until push_ready takes it.
  task automatic push_flits(input int n);
    logic [31:0] rnd;
    int          sent_count;
    sent_count = 0;
    while (sent_count < n) begin
      rnd        = $random(seed);
      push_valid = 1'b1;
      push_data  = credit_link_pkg::flit_t'(rnd);
      @(negedge clk);
      while (!push_ready) begin
        @(negedge clk);
      end
      expected_q.push_back(push_data);
      sent_count++;
      @(posedge clk);
      #drive_delay;
    end
    push_valid = 1'b0;
  endtask

  // Offers flits until push_ready drops. With out_ready low no credit returns,
  // so the first low push_ready stays low.
  task automatic push_until_full(output int accepted);
    logic [31:0] rnd;
    accepted   = 0;
    push_valid = 1'b1;
    while (accepted <= 2 * max_credit) begin
      rnd       = $random(seed);
      push_data = credit_link_pkg::flit_t'(rnd);
      @(negedge clk);
      if (!push_ready) begin
        break;
      end
      expected_q.push_back(push_data);
      accepted++;
      @(posedge clk);
      #drive_delay;
    end
    @(posedge clk);
    #drive_delay;
    push_valid = 1'b0;
  endtask

  task automatic drain_flits(input int n);
    out_ready = 1'b1;
    while (got_q.size() < n) begin
      @(negedge clk);
      if (out_valid) begin
        got_q.push_back(out_data);
      end
      @(posedge clk);
      #drive_delay;
    end
    out_ready = 1'b0;
  endtask

  // The link must keep every flit and its order.
  task automatic compare_flits(input string what);
    check(32'(got_q.size()), 32'(expected_q.size()), {what, " flit count"});
    for (int i = 0; (i < got_q.size()) && (i < expected_q.size()); i++) begin
      check(32'(got_q[i]), 32'(expected_q[i]), $sformatf("%s flit %0d", what, i));
    end
    total_flits += expected_q.size();
    got_q.delete();
    expected_q.delete();
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin : main_sequence
    credit_regs_pkg::apb_data_t rdata;
    logic                       err;
    int                         accepted;
    seed        = 32'h7a64;
    error_count = 0;
    check_count = 0;
    total_flits = 0;
    clk         = 1'b0;
    arst_n      = 1'b0;
    push_valid  = 1'b0;
    push_data   = '0;
    out_ready   = 1'b0;
    apb_req     = '0;
    repeat (3) @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;

    // Reset state with the full pool free.
    @(negedge clk);
    check(32'(push_ready), 1, "push_ready after reset");
    check(32'(out_valid), 0, "out_valid after reset");
    @(posedge clk);
    #drive_delay;
    apb_read(credit_regs_pkg::reg_count, rdata, err);
    check(rdata, max_credit, "reg_count after reset");
    apb_read(credit_regs_pkg::reg_available, rdata, err);
    check(rdata, max_credit, "reg_available after reset");

    // Streaming with the output always ready.
    fork
      push_flits(20);
      drain_flits(20);
    join
    compare_flits("streaming");
    wait_count(max_credit, "reg_count after streaming");

    // Back-pressure takes the whole pool.
    push_until_full(accepted);
    check(32'(accepted), max_credit, "flits accepted under back-pressure");
    apb_read(credit_regs_pkg::reg_count, rdata, err);
    check(rdata, 0, "reg_count with the pool spent");
    drain_flits(accepted);
    compare_flits("back-pressure");
    wait_count(max_credit, "reg_count after back-pressure");

    // One credit withheld leaves three usable.
    apb_write(credit_regs_pkg::reg_withhold, 1, err);
    push_until_full(accepted);
    check(32'(accepted), max_credit - 1, "flits accepted with withhold 1");
    apb_read(credit_regs_pkg::reg_withhold, rdata, err);
    check(rdata, 1, "reg_withhold read back");
    drain_flits(accepted);
    compare_flits("withhold");
    apb_write(credit_regs_pkg::reg_withhold, 0, err);
    wait_count(max_credit, "reg_count after withhold");

    // Flit counter, its clear, and bus errors.
    apb_read(credit_regs_pkg::reg_flits, rdata, err);
    check(rdata, 32'(total_flits), "reg_flits total");
    apb_write(credit_regs_pkg::reg_flits, 0, err);
    check(32'(err), 0, "pslverr on reg_flits clear");
    apb_read(credit_regs_pkg::reg_flits, rdata, err);
    check(rdata, 0, "reg_flits after clear");
    apb_read(8'h10, rdata, err);
    check(32'(err), 1, "pslverr on unmapped read");
    apb_write(credit_regs_pkg::reg_count, 32'h55, err);
    check(32'(err), 1, "pslverr on reg_count write");

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/credit_link_pkg.sv
logic/credit_regs_pkg.sv
logic/credit_counter.sv
logic/credit_sender.sv
logic/credit_receiver.sv
logic/credit_apb_regs.sv
logic/credit_link_top.sv
tests/credit_link_tb.sv
